// ==== src.f ====
+incdir+logic
logic/us_ctrl_pkg.sv
logic/us_data_pkg.sv
logic/us_ctrl_decode.sv
logic/us_fire_fsm.sv
logic/us_sample_gate.sv
logic/us_acq_top.sv
verification/tb_clock_gen.sv
verification/tb_us_acq.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps
TOP       := tb_us_acq
FILELIST  := src.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/tb_us_acq.sv ====
/*
	testbench for the acquisition controller: a table of firings and
	clears, random adc frames, checks on timing, frames and status
*/
`timescale 1ns/100ps
`include "us_acq_config.svh"

module tb_us_acq
	import us_ctrl_pkg::*;
	import us_data_pkg::*;
();

	localparam int N_ROWS = 8;
	localparam int WATCH  = `US_START_DELAY + 4; // quiet cycles watched after done

	typedef struct packed {
		timing_cfg_t timing;
		logic        fire;     // run a firing
		logic        clear;    // soft reset, mid-window when firing
		logic        exp_done;
	} row_t;

	logic        adc_clk;
	logic        rst_n;
	ctrl_word_t  ctrl;
	timing_cfg_t timing;
	adc_frame_t  adc_frame;
	logic        tx_en;
	logic        adc_pwdn;
	logic        adc_stby;
	logic        pulser_en;
	status_t     status;
	fifo_frame_t fifo_frame;
	logic        fifo_valid;

	row_t        rows [N_ROWS];
	string       row_name [N_ROWS];
	string       pin_name [3] = '{"pulser_en", "adc_stby", "adc_pwdn"};
	string       cur_name = "reset";
	logic [2:0]  pins_now = 3'b000;  // {pwdn, stby, pulser_en} last driven
	integer      seed = 32'hadf6;
	adc_frame_t  frame_hist [$];     // frame on the bus at each falling edge
	int unsigned cyc_count = 0;
	int unsigned cyc_limit = 0;

	tb_clock_gen u_clk (
		.adc_clk (adc_clk),
		.rst_n   (rst_n)
	);

	us_acq_top u_dut (
		.adc_clk    (adc_clk),
		.rst_n      (rst_n),
		.ctrl       (ctrl),
		.timing     (timing),
		.adc_frame  (adc_frame),
		.tx_en      (tx_en),
		.adc_pwdn   (adc_pwdn),
		.adc_stby   (adc_stby),
		.pulser_en  (pulser_en),
		.status     (status),
		.fifo_frame (fifo_frame),
		.fifo_valid (fifo_valid)
	);

	// ============================================================
	// checks
	// ============================================================
	task automatic stop_run();
		$display("STATUS: FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_frame(input string test, input fifo_frame_t exp, input fifo_frame_t act);
		if (act !== exp) begin
			$display("ERROR %s: fifo_frame expected %h actual %h", test, exp, act);
			stop_run();
		end
	endtask

	task automatic check_status(input string test, input status_t exp, input status_t act);
		if (act !== exp) begin
			$display("ERROR %s: status {busy,done} expected %b actual %b", test, exp, act);
			stop_run();
		end
	endtask

	task automatic check_level(input string test, input string sig, input logic exp,
			input logic act);
		if (act !== exp) begin
			$display("ERROR %s: %s expected %b actual %b", test, sig, exp, act);
			stop_run();
		end
	endtask

	task automatic check_count(input string test, input string what, input int exp, input int act);
		if (act != exp) begin
			$display("ERROR %s: %s expected %0d actual %0d", test, what, exp, act);
			stop_run();
		end
	endtask

	// samples pad to fifo width with zeros
	function automatic fifo_frame_t zero_extend(input adc_frame_t f);
		fifo_frame_t w;
		for (int ch = 0; ch < `US_CHANNELS; ch++) begin
			w[ch] = fifo_word_t'(f[ch]);
		end
		return w;
	endfunction

	function automatic adc_frame_t random_frame();
		adc_frame_t f;
		for (int ch = 0; ch < `US_CHANNELS; ch++) begin
			f[ch] = sample_t'($random(seed));
		end
		return f;
	endfunction

	// ============================================================
	// stimulus table
	// ============================================================
	task automatic set_row(input int idx, input string name, input int unsigned tx,
			input int unsigned dly, input int unsigned smp, input logic fire,
			input logic clr, input logic done);
		row_name[idx]               = name;
		rows[idx].timing.tx_len     = tx;
		rows[idx].timing.init_delay = dly;
		rows[idx].timing.samples    = smp;
		rows[idx].fire              = fire;
		rows[idx].clear             = clr;
		rows[idx].exp_done          = done;
	endtask

	task automatic load_table();
		//           name               tx dly smp fire clr done
		set_row(0, "fire_basic",      3, 4,  9,  1'b1, 1'b0, 1'b1);
		set_row(1, "zero_delay",      2, 0,  5,  1'b1, 1'b0, 1'b1);
		set_row(2, "single_sample",   1, 2,  1,  1'b1, 1'b0, 1'b1);
		set_row(3, "clear_done",      0, 0,  0,  1'b0, 1'b1, 1'b0);
		set_row(4, "long_window",     4, 6,  12, 1'b1, 1'b0, 1'b1);
		set_row(5, "abort_acq",       3, 2,  12, 1'b1, 1'b1, 1'b0);
		set_row(6, "after_abort",     2, 3,  4,  1'b1, 1'b0, 1'b1);
		set_row(7, "zero_delay_long", 5, 0,  14, 1'b1, 1'b0, 1'b1);
	endtask

	// adc bus changes every cycle
	initial begin
		adc_frame <= '0;
		forever begin
			@(posedge adc_clk);
			adc_frame <= random_frame();
		end
	end

	// capture happens one edge after the frame sat on the bus
	always @(negedge adc_clk) begin
		if (rst_n && fifo_valid && frame_hist.size() > 0) begin
			check_frame(cur_name, zero_extend(frame_hist[$]), fifo_frame);
		end
		frame_hist.push_back(adc_frame);
		if (frame_hist.size() > 4) begin
			frame_hist.delete(0);
		end
	end

	always @(posedge adc_clk) begin
		if (rst_n) begin
			cyc_count <= cyc_count + 1;
			if (cyc_count >= cyc_limit) begin
				$display("timeout: run did not finish within %0d cycles", cyc_limit);
				stop_run();
			end
		end
	end

	// ============================================================
	// sequences
	// ============================================================
	task automatic drive_pins(input logic [2:0] pins); // {pwdn, stby, pulser_en}
		logic [2:0] seen;
		@(posedge adc_clk);
		ctrl.adc_pwdn  <= pins[2];
		ctrl.adc_stby  <= pins[1];
		ctrl.pulser_en <= pins[0];
		@(negedge adc_clk);
		seen = {adc_pwdn, adc_stby, pulser_en}; // not registered yet
		for (int b = 0; b < 3; b++) begin
			check_level("ctrl_pins", pin_name[b], pins_now[b], seen[b]);
		end
		@(negedge adc_clk);
		seen = {adc_pwdn, adc_stby, pulser_en};
		for (int b = 0; b < 3; b++) begin
			check_level("ctrl_pins", pin_name[b], pins[b], seen[b]);
		end
		pins_now = pins;
	endtask

	task automatic run_clear(input int idx);
		status_t exp_st;
		exp_st      = '0;
		exp_st.done = rows[idx].exp_done;
		@(posedge adc_clk);
		ctrl.fsm_reset <= 1'b1;
		repeat (3) @(posedge adc_clk);
		ctrl.fsm_reset <= 1'b0;
		@(negedge adc_clk);
		check_status(row_name[idx], exp_st, status);
		check_level(row_name[idx], "tx_en", 1'b0, tx_en);
	endtask

	// index i counts edges from the one that drives tx_start high
	task automatic run_firing(input int idx);
		timing_cfg_t t;
		status_t     exp_st;
		int          len;
		int          i;
		int          first_tx;
		int          last_tx;
		int          n_tx;
		int          first_val;
		int          n_val;
		int          n_busy;
		int          done_at;
		int          clear_at;
		logic        retrig;
		logic        running;
		t         = rows[idx].timing;
		len       = int'(t.tx_len + t.init_delay + t.samples); // busy length
		retrig    = !rows[idx].clear && (len >= WATCH + 2);  // second edge lands while busy
		first_tx  = -1;
		last_tx   = -1;
		n_tx      = 0;
		first_val = -1;
		n_val     = 0;
		n_busy    = 0;
		done_at   = -1;
		clear_at  = -1;
		running   = 1'b1;
		i         = 0;
		while (running) begin
			@(posedge adc_clk);
			if (i == 0) begin
				timing        <= t;
				ctrl.tx_start <= 1'b1;
			end
			if (retrig && first_tx >= 0 && i == first_tx + 1) begin
				ctrl.tx_start <= 1'b0;
			end
			if (retrig && first_tx >= 0 && i == first_tx + 2) begin
				ctrl.tx_start <= 1'b1; // edge during transmit
			end
			if (rows[idx].clear && first_val >= 0 && clear_at < 0) begin
				ctrl.fsm_reset <= 1'b1; // cut the window
				clear_at = i;
			end
			if (clear_at >= 0 && i == clear_at + 3) begin
				ctrl.fsm_reset <= 1'b0;
			end
			@(negedge adc_clk);
			if (tx_en) begin
				if (first_tx < 0) first_tx = i;
				last_tx = i;
				n_tx++;
			end
			if (fifo_valid) begin
				if (first_val < 0) first_val = i;
				n_val++;
			end
			if (status.busy) n_busy++;
			if (status.done && first_tx >= 0 && done_at < 0) done_at = i;
			if (done_at >= 0 && i >= done_at + WATCH) running = 1'b0;
			if (clear_at >= 0 && i >= clear_at + 8) running = 1'b0;
			i++;
		end
		@(posedge adc_clk);
		ctrl.tx_start <= 1'b0;
		@(negedge adc_clk);

		// tx_start first seen at edge 1
		check_count(row_name[idx], "start edge to tx_en", `US_START_DELAY + 2, first_tx - 1);
		check_count(row_name[idx], "tx_en cycles", int'(t.tx_len), n_tx);
		check_count(row_name[idx], "tx_en span", int'(t.tx_len), last_tx - first_tx + 1);
		check_count(row_name[idx], "tx_en to first frame gap", int'(t.init_delay) + 1,
			first_val - last_tx - 1);
		if (rows[idx].clear) begin
			check_level(row_name[idx], "window cut short", 1'b1, n_val < int'(t.samples));
			check_level(row_name[idx], "tx_en after clear", 1'b0, tx_en);
			check_level(row_name[idx], "fifo_valid after clear", 1'b0, fifo_valid);
		end else begin
			check_count(row_name[idx], "frames", int'(t.samples), n_val);
			check_count(row_name[idx], "busy cycles", len, n_busy);
			check_count(row_name[idx], "done after last frame",
				first_val + int'(t.samples) - 1, done_at);
		end
		exp_st      = '0;
		exp_st.done = rows[idx].exp_done;
		check_status(row_name[idx], exp_st, status);
	endtask

	// ============================================================
	// main
	// ============================================================
	initial begin
		ctrl   <= '0;
		timing <= '0;
		load_table();
		for (int r = 0; r < N_ROWS; r++) begin
			cyc_limit += rows[r].timing.tx_len + rows[r].timing.init_delay
				+ rows[r].timing.samples + 32'd40;
		end
		wait (rst_n === 1'b1);
		@(negedge adc_clk);
		check_level("reset", "tx_en", 1'b0, tx_en);
		check_level("reset", "fifo_valid", 1'b0, fifo_valid);
		check_status("reset", '0, status);

		drive_pins(3'b101);
		drive_pins(3'b010);
		drive_pins(3'b001); // pulser on for the firings

		for (int r = 0; r < N_ROWS; r++) begin
			cur_name = row_name[r];
			if (rows[r].fire) begin
				run_firing(r);
			end else if (rows[r].clear) begin
				run_clear(r);
			end
			repeat (2) @(negedge adc_clk); // tx_start low between rows
		end

		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== verification/tb_clock_gen.sv ====
/*
	testbench clock and reset: 4 ns adc clock,
	rst_n held low for the first 8 rising edges
*/
`timescale 1ns/100ps

module tb_clock_gen (
	output logic adc_clk,
	output logic rst_n
);

	initial begin
		adc_clk = 1'b0;
		forever #2 adc_clk = ~adc_clk; // 250 MHz
	end

	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge adc_clk);
		rst_n <= 1'b1; // release on the 8th edge
	end

endmodule

// ==== logic/us_acq_top.sv ====
/*
	ultrasound acquisition controller top: control decode,
	firing sequencer and sample gate on the adc clock
*/
`timescale 1ns/100ps

module us_acq_top
	import us_ctrl_pkg::*;
	import us_data_pkg::*;
(
	input  logic        adc_clk,    // recovered adc clock
	input  logic        rst_n,
	input  ctrl_word_t  ctrl,       // host levels
	input  timing_cfg_t timing,     // host levels
	input  adc_frame_t  adc_frame,  // parallel samples, every cycle
	output logic        tx_en,      // to the beamformer tx pin
	output logic        adc_pwdn,
	output logic        adc_stby,
	output logic        pulser_en,
	output status_t     status,
	output fifo_frame_t fifo_frame,
	output logic        fifo_valid  // no ready, every frame taken
);

	logic fire_start; // delayed firing strobe
	logic fsm_clear;  // soft reset level
	logic acq_en;     // acquisition window

	us_ctrl_decode u_decode (
		.adc_clk    (adc_clk),
		.rst_n      (rst_n),
		.ctrl       (ctrl),
		.fire_start (fire_start),
		.fsm_clear  (fsm_clear),
		.adc_pwdn   (adc_pwdn),
		.adc_stby   (adc_stby),
		.pulser_en  (pulser_en)
	);

	us_fire_fsm u_fire (
		.adc_clk    (adc_clk),
		.rst_n      (rst_n),
		.fire_start (fire_start),
		.fsm_clear  (fsm_clear),
		.timing     (timing),
		.tx_en      (tx_en),
		.acq_en     (acq_en),
		.status     (status)
	);

	us_sample_gate u_gate (
		.adc_clk    (adc_clk),
		.rst_n      (rst_n),
		.acq_en     (acq_en),
		.adc_frame  (adc_frame),
		.fifo_frame (fifo_frame),
		.fifo_valid (fifo_valid)
	);

endmodule

// ==== logic/us_sample_gate.sv ====
/*
	acquisition gate: captures each adc frame inside the window
	and presents it as zero-extended fifo words with a valid strobe
*/
`timescale 1ns/100ps
`include "us_acq_config.svh"

module us_sample_gate
	import us_data_pkg::*;
(
	input  logic        adc_clk,
	input  logic        rst_n,
	input  logic        acq_en,     // window open
	input  adc_frame_t  adc_frame,
	output fifo_frame_t fifo_frame,
	output logic        fifo_valid  // one per captured frame
);

	// valid trails the window by one cycle
	always_ff @(posedge adc_clk or negedge rst_n) begin
		if (!rst_n) begin
			fifo_valid <= 1'b0;
		end else begin
			fifo_valid <= acq_en;
		end
	end

	// frame register, holds last capture while closed
	always_ff @(posedge adc_clk) begin
		if (acq_en) begin
			for (int ch = 0; ch < `US_CHANNELS; ch++) begin
				// pad upper bits, sink expects 16-bit words
				fifo_frame[ch] <= {{(`US_WORD_W - `US_SAMPLE_W){1'b0}}, adc_frame[ch]};
			end
		end
	end

	// no frame leaves with unknown sample bits
	a_valid_known: assert property (
		@(posedge adc_clk) disable iff (!rst_n)
		fifo_valid |-> !$isunknown(fifo_frame)
	) else $error("fifo_valid with unknown sample bits");

endmodule

// ==== logic/us_fire_fsm.sv ====
/*
	pulse-echo sequencer: transmit enable, initial dead time,
	then the acquisition window, with done held afterwards
*/
`timescale 1ns/100ps
`include "us_acq_config.svh"

module us_fire_fsm
	import us_ctrl_pkg::*;
(
	input  logic        adc_clk,
	input  logic        rst_n,
	input  logic        fire_start, // from the delayed pulser
	input  logic        fsm_clear,
	input  timing_cfg_t timing,
	output logic        tx_en,
	output logic        acq_en,
	output status_t     status
);

	fire_state_t             state;
	logic [`US_TIMING_W-1:0] phase_cnt;  // cycles left in phase, minus one
	logic [`US_TIMING_W-1:0] delay_q;    // latched init_delay
	logic [`US_TIMING_W-1:0] samples_q;  // latched samples
	logic                    fire_ok;    // pulse seen while idle

	// busy phases ignore the pulse
	assign fire_ok = fire_start & ((state == IDLE) | (state == DONE));

	// timing snapshot for the later phases
	always_ff @(posedge adc_clk) begin
		if (fire_ok) begin
			delay_q   <= timing.init_delay;
			samples_q <= timing.samples;
		end
	end

	// ============================================================
	// state and phase counter
	// ============================================================
	always_ff @(posedge adc_clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= IDLE;
			phase_cnt <= '0;
		end else if (fsm_clear) begin
			state     <= IDLE; // abort any firing
			phase_cnt <= '0;
		end else begin
			case (state)
				IDLE, DONE: begin
					if (fire_ok) begin
						state     <= TX;
						phase_cnt <= timing.tx_len - 1'b1; // tx_len taken live
					end
				end
				TX: begin
					if (phase_cnt != '0) begin
						phase_cnt <= phase_cnt - 1'b1;
					end else if (delay_q == '0) begin
						state     <= ACQ; // no dead time
						phase_cnt <= samples_q - 1'b1;
					end else begin
						state     <= WAIT;
						phase_cnt <= delay_q - 1'b1;
					end
				end
				WAIT: begin
					if (phase_cnt != '0) begin
						phase_cnt <= phase_cnt - 1'b1;
					end else begin
						state     <= ACQ;
						phase_cnt <= samples_q - 1'b1;
					end
				end
				ACQ: begin
					if (phase_cnt != '0) begin
						phase_cnt <= phase_cnt - 1'b1;
					end else begin
						state <= DONE; // window closed
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// outputs straight off the state register
	assign tx_en  = (state == TX);
	assign acq_en = (state == ACQ);

	always_comb begin
		status      = '0;
		status.busy = (state == TX) | (state == WAIT) | (state == ACQ);
		status.done = (state == DONE);
	end

	// window opens straight out of transmit or dead time
	a_acq_after_tx: assert property (
		@(posedge adc_clk) disable iff (!rst_n)
		$rose(acq_en) |-> ($past(tx_en) || $past(state == WAIT))
	) else $error("acq_en opened without transmit or dead time");

	// done only as the window closes
	a_done_after_acq: assert property (
		@(posedge adc_clk) disable iff (!rst_n)
		$rose(status.done) |-> $past(acq_en)
	) else $error("status.done raised without a closing window");

endmodule

// ==== logic/us_ctrl_decode.sv ====
/*
	control word decode: registers the host word, drives the adc
	control pins and turns a tx_start edge into a delayed fire pulse
*/
`timescale 1ns/100ps
`include "us_acq_config.svh"

module us_ctrl_decode
	import us_ctrl_pkg::*;
(
	input  logic       adc_clk,
	input  logic       rst_n,
	input  ctrl_word_t ctrl,
	output logic       fire_start,  // one-cycle strobe
	output logic       fsm_clear,   // level
	output logic       adc_pwdn,
	output logic       adc_stby,
	output logic       pulser_en
);

	localparam int DLY_W = $clog2(`US_START_DELAY + 1);

	ctrl_word_t       ctrl_q;     // registered host word
	logic             start_rise; // tx_start low -> high
	logic             pending;    // delay running
	logic [DLY_W-1:0] dly_cnt;

	// compare against last sampled value
	assign start_rise = ctrl.tx_start & ~ctrl_q.tx_start;

	always_ff @(posedge adc_clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_q <= '0;
		end else begin
			ctrl_q <= ctrl;
		end
	end

	// ============================================================
	// delayed pulser
	// ============================================================
	// arm on the edge, count down, fire once the count is spent
	always_ff @(posedge adc_clk or negedge rst_n) begin
		if (!rst_n) begin
			pending    <= 1'b0;
			dly_cnt    <= '0;
			fire_start <= 1'b0;
		end else begin
			fire_start <= 1'b0; // default low, strobe only
			if (fsm_clear) begin
				pending <= 1'b0; // soft reset drops a pending shot
				dly_cnt <= '0;
			end else if (pending) begin
				if (dly_cnt == '0) begin
					fire_start <= 1'b1;
					pending    <= 1'b0;
				end else begin
					dly_cnt <= dly_cnt - 1'b1;
				end
			end else if (start_rise) begin
				pending <= 1'b1; // later edges ignored until fired
				dly_cnt <= DLY_W'(`US_START_DELAY);
			end
		end
	end

	// one register stage to the pins
	assign fsm_clear = ctrl_q.fsm_reset;
	assign adc_pwdn  = ctrl_q.adc_pwdn;
	assign adc_stby  = ctrl_q.adc_stby;
	assign pulser_en = ctrl_q.pulser_en;

	// a single tx_start edge never yields a stretched pulse
	a_fire_one_cycle: assert property (
		@(posedge adc_clk) disable iff (!rst_n)
		fire_start |=> !fire_start
	) else $error("fire_start held for more than one cycle");

endmodule

// ==== logic/us_data_pkg.sv ====
/*
	sample-path types: raw adc samples and channel frames,
	plus the zero-extended fifo words and frames
*/
`include "us_acq_config.svh"

package us_data_pkg;

	// ============================================================
	// adc side
	// ============================================================
	typedef logic [`US_SAMPLE_W-1:0] sample_t;    // one raw sample

	// one sample per channel, channel 0 in the low bits
	typedef sample_t [`US_CHANNELS-1:0] adc_frame_t;

	// ============================================================
	// fifo side
	// ============================================================
	typedef logic [`US_WORD_W-1:0] fifo_word_t;   // upper bits zero

	// one word per channel sink
	typedef fifo_word_t [`US_CHANNELS-1:0] fifo_frame_t;

endpackage

// ==== logic/us_ctrl_pkg.sv ====
/*
	control-side types: host control word, firing timing
	configuration, status flags and sequencer states
*/
`include "us_acq_config.svh"

package us_ctrl_pkg;

	// host control word, msb first as packed on the host side
	typedef struct packed {
		logic adc_pwdn;   // adc power-down
		logic adc_stby;   // adc standby
		logic fsm_reset;  // soft sequencer reset
		logic pulser_en;  // pulser supply enable
		logic tx_start;   // firing request, rising edge
	} ctrl_word_t;

	// timing fields, sampled when a firing is accepted
	typedef struct packed {
		logic [`US_TIMING_W-1:0] tx_len;     // transmit enable cycles
		logic [`US_TIMING_W-1:0] init_delay; // dead time before window
		logic [`US_TIMING_W-1:0] samples;    // acquisition window length
	} timing_cfg_t;

	typedef struct packed {
		logic busy; // tx, wait or acq
		logic done; // window closed, held
	} status_t;

	// pulse-echo sequencer states
	typedef enum logic [2:0] {
		IDLE = 3'd0,
		TX   = 3'd1,
		WAIT = 3'd2,
		ACQ  = 3'd3,
		DONE = 3'd4
	} fire_state_t;

endpackage

// ==== logic/us_acq_config.svh ====
/*
	build-wide sizes and timing constants for the
	ultrasound pulse-echo acquisition controller
*/
`ifndef US_ACQ_CONFIG_SVH
`define US_ACQ_CONFIG_SVH

// ============================================================
// ADC frame geometry
// ============================================================
`define US_CHANNELS     8   // channels per ADC frame
`define US_SAMPLE_W     14  // raw ADC sample bits
`define US_WORD_W       16  // fifo word per channel, sample zero-extended

// ============================================================
// firing timing
// ============================================================
// width of tx_len, init_delay and samples
`define US_TIMING_W     32
// cycles from tx_start edge to firing pulse
`define US_START_DELAY  10

`endif
